/* vga_pkg.sv */
package vga_pkg;

    // counter width, both axes
    localparam int cnt_w = 11;
    // colour word, 4 bits per channel
    localparam int rgb_w = 12;

    // horizontal timing in pixels
    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;
    // 800 pixels per line
    localparam int h_total  = h_active + h_front + h_sync + h_back;

    // vertical timing in lines
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    // 525 lines per frame
    localparam int v_total  = v_active + v_front + v_sync + v_back;

    // sync windows, end exclusive
    localparam int h_sync_start = h_active + h_front;
    localparam int h_sync_end   = h_sync_start + h_sync;
    localparam int v_sync_start = v_active + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;

    // one pixel slot as it moves down the drawing chain
    // syncs and blanks are active high
    typedef struct packed {
        logic [cnt_w-1:0] hcount;
        logic [cnt_w-1:0] vcount;
        logic             hsync;
        logic             vsync;
        logic             hblnk;
        logic             vblnk;
        logic [rgb_w-1:0] rgb;
    } vga_sig_t;

endpackage

/* game_pkg.sv */
package game_pkg;

    // colours, 4-4-4 rgb
    localparam logic [11:0] bg_rgb     = 12'h024;
    localparam logic [11:0] border_rgb = 12'hccc;
    localparam logic [11:0] paddle_rgb = 12'hfff;
    // dark orange for the game-over overlay
    localparam logic [11:0] over_rgb   = 12'h820;

    // frame border width, pixels
    localparam int border_w = 8;

    // paddle size and left columns
    localparam int          paddle_w = 10;
    localparam int          paddle_h = 80;
    localparam logic [9:0]  p1_x     = 10'd24;
    localparam logic [9:0]  p2_x     = 10'd606;

    // overlay rectangles, both bounds exclusive
    // index 0 is rectangle 1
    // rects 1-2 share a row, so do 3-4
    localparam int ov_rects = 6;
    localparam logic [ov_rects-1:0][9:0] ov_x_start = {
        10'd270, 10'd230, 10'd340, 10'd160, 10'd340, 10'd160
    };
    localparam logic [ov_rects-1:0][9:0] ov_x_end = {
        10'd370, 10'd410, 10'd480, 10'd300, 10'd480, 10'd300
    };
    localparam logic [ov_rects-1:0][9:0] ov_y_start = {
        10'd350, 10'd300, 10'd220, 10'd220, 10'd140, 10'd140
    };
    localparam logic [ov_rects-1:0][9:0] ov_y_end = {
        10'd380, 10'd330, 10'd280, 10'd280, 10'd200, 10'd200
    };

    // top line of each paddle
    typedef struct packed {
        logic [9:0] p1_y;
        logic [9:0] p2_y;
    } paddle_pos_t;

    // result from game logic
    // 1 player 1 won, 2 player 2 won, 3 draw
    typedef logic [1:0] gameover_t;
    localparam gameover_t go_playing = 2'd0;

endpackage

/* vga_timing.sv */
`timescale 1ns/1ps

module vga_timing import vga_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    output vga_sig_t vga_out
);

    // last values before wrap
    localparam logic [cnt_w-1:0] h_last = cnt_w'(h_total - 1);
    localparam logic [cnt_w-1:0] v_last = cnt_w'(v_total - 1);

    logic [cnt_w-1:0] hcnt;
    logic [cnt_w-1:0] vcnt;
    vga_sig_t         vga_nxt;

    // free-running position counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == h_last) begin
            hcnt <= '0;
            // end of line steps the line counter
            if (vcnt == v_last) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 1'b1;
            end
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // syncs and blanks from the current count
    always_comb begin
        vga_nxt.hcount = hcnt;
        vga_nxt.vcount = vcnt;
        // sync windows between front and back porch
        vga_nxt.hsync  = (hcnt >= cnt_w'(h_sync_start)) && (hcnt < cnt_w'(h_sync_end));
        vga_nxt.vsync  = (vcnt >= cnt_w'(v_sync_start)) && (vcnt < cnt_w'(v_sync_end));
        // blank everything outside the visible area
        vga_nxt.hblnk  = (hcnt >= cnt_w'(h_active));
        vga_nxt.vblnk  = (vcnt >= cnt_w'(v_active));
        // colour is added by the drawing stages
        vga_nxt.rgb    = '0;
    end

    // registered outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_nxt;
        end
    end

endmodule

/* draw_background.sv */
`timescale 1ns/1ps

module draw_background import vga_pkg::*, game_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  vga_sig_t vga_in,
    output vga_sig_t vga_out
);

    // inner edges of the border band
    localparam logic [cnt_w-1:0] left_lim  = cnt_w'(border_w);
    localparam logic [cnt_w-1:0] right_lim = cnt_w'(h_active - border_w);
    localparam logic [cnt_w-1:0] top_lim   = cnt_w'(border_w);
    localparam logic [cnt_w-1:0] bot_lim   = cnt_w'(v_active - border_w);

    logic     blank;
    logic     on_border;
    vga_sig_t vga_nxt;

    always_comb begin
        blank     = vga_in.hblnk | vga_in.vblnk;
        // any of the four edges
        on_border = (vga_in.hcount < left_lim) || (vga_in.hcount >= right_lim) ||
                    (vga_in.vcount < top_lim) || (vga_in.vcount >= bot_lim);

        // timing fields pass as they are
        vga_nxt = vga_in;
        if (blank) begin
            // nothing shows during blanking
            vga_nxt.rgb = '0;
        end else if (on_border) begin
            vga_nxt.rgb = border_rgb;
        end else begin
            vga_nxt.rgb = bg_rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_nxt;
        end
    end

endmodule

/* draw_players.sv */
`timescale 1ns/1ps

module draw_players import vga_pkg::*, game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  paddle_pos_t paddles,
    input  vga_sig_t    vga_in,
    output vga_sig_t    vga_out
);

    paddle_pos_t paddles_q;
    logic        blank;
    logic        in_p1;
    logic        in_p2;
    vga_sig_t    vga_nxt;

    // pixel inside a paddle whose top-left corner is (x, y)
    // spans are end exclusive, sums kept at counter width
    function automatic logic in_paddle(
        input logic [cnt_w-1:0] hc,
        input logic [cnt_w-1:0] vc,
        input logic [9:0]       x,
        input logic [9:0]       y
    );
        logic [cnt_w-1:0] x0;
        logic [cnt_w-1:0] y0;
        logic [cnt_w-1:0] x1;
        logic [cnt_w-1:0] y1;
        x0 = {1'b0, x};
        y0 = {1'b0, y};
        x1 = x0 + cnt_w'(paddle_w);
        y1 = y0 + cnt_w'(paddle_h);
        return (hc >= x0) && (hc < x1) && (vc >= y0) && (vc < y1);
    endfunction

    // heights held in a register so a comparison sees one stable value
    always_ff @(posedge clk) begin
        paddles_q <= paddles;
    end

    always_comb begin
        blank = vga_in.hblnk | vga_in.vblnk;
        in_p1 = in_paddle(vga_in.hcount, vga_in.vcount, p1_x, paddles_q.p1_y);
        in_p2 = in_paddle(vga_in.hcount, vga_in.vcount, p2_x, paddles_q.p2_y);

        vga_nxt = vga_in;
        // paint over the background, never into blanking
        if (!blank && (in_p1 || in_p2)) begin
            vga_nxt.rgb = paddle_rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_nxt;
        end
    end

endmodule

/* draw_gameover.sv */
`timescale 1ns/1ps

module draw_gameover import vga_pkg::*, game_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  gameover_t gameover,
    input  vga_sig_t  vga_in,
    output vga_sig_t  vga_out
);

    logic     over;
    logic     over_nxt;
    logic     in_rect;
    vga_sig_t vga_nxt;

    // sticky flag, only reset brings the game back
    always_comb begin
        over_nxt = over | (gameover != go_playing);
    end

    // hit test against all overlay rectangles
    // strict compare on both sides, edges keep the picture
    always_comb begin
        in_rect = 1'b0;
        for (int i = 0; i < ov_rects; i++) begin
            if ((vga_in.hcount > {1'b0, ov_x_start[i]}) &&
                (vga_in.hcount < {1'b0, ov_x_end[i]}) &&
                (vga_in.vcount > {1'b0, ov_y_start[i]}) &&
                (vga_in.vcount < {1'b0, ov_y_end[i]})) begin
                in_rect = 1'b1;
            end
        end
    end

    always_comb begin
        vga_nxt = vga_in;
        // overlay only once the game has ended
        if (over && in_rect) begin
            vga_nxt.rgb = over_rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
            over    <= 1'b0;
        end else begin
            vga_out <= vga_nxt;
            over    <= over_nxt;
        end
    end

endmodule

/* game_display_top.sv */
`timescale 1ns/1ps

module game_display_top import vga_pkg::*, game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  paddle_pos_t paddles,
    input  gameover_t   gameover,
    output vga_sig_t    vga_out
);

    // stage boundaries, one register step each
    vga_sig_t vga_tim;
    vga_sig_t vga_bg;
    vga_sig_t vga_pl;

    // counters, syncs, blanks
    vga_timing u_vga_timing (
        .clk     (clk),
        .rst     (rst),
        .vga_out (vga_tim)
    );

    // fill and border
    draw_background u_draw_background (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (vga_tim),
        .vga_out (vga_bg)
    );

    // both paddles
    draw_players u_draw_players (
        .clk     (clk),
        .rst     (rst),
        .paddles (paddles),
        .vga_in  (vga_bg),
        .vga_out (vga_pl)
    );

    // end-of-game overlay, last stage
    draw_gameover u_draw_gameover (
        .clk      (clk),
        .rst      (rst),
        .gameover (gameover),
        .vga_in   (vga_pl),
        .vga_out  (vga_out)
    );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    input  logic restart,
    output logic clk,
    output logic rst
);

    // 8 ns period
    localparam real half_period = 4.0;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // power-on reset, two cycles
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

    // reset again on request, same length
    always @(posedge restart) begin
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* tb_game_display.sv */
`timescale 1ns/1ps

module tb_game_display import vga_pkg::*, game_pkg::*; ();

    // one frame of pixel clocks
    localparam int frame_cycles = h_total * v_total;
    // reset and background test about 2 frames, then up to 2 per checked frame
    // for 4 more checked frames plus a reset, rounded up
    localparam int test_frames = 11;
    localparam int timeout_cycles = test_frames * frame_cycles * 5 / 4;
    localparam int paddle_area = 2 * paddle_w * paddle_h;

    logic        clk;
    logic        rst;
    logic        restart;
    paddle_pos_t paddles;
    gameover_t   gameover;
    vga_sig_t    vga_out;

    int          cycles;
    int          errors;
    logic [31:0] lcg_state;

    tb_clock u_clock (
        .restart (restart),
        .clk     (clk),
        .rst     (rst)
    );

    game_display_top UUT (
        .clk      (clk),
        .rst      (rst),
        .paddles  (paddles),
        .gameover (gameover),
        .vga_out  (vga_out)
    );

    // run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("sim failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    // numerical recipes constants
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // heights that keep both paddles fully on screen
    function automatic paddle_pos_t random_paddles();
        paddle_pos_t p;
        p.p1_y = 10'((lcg_next() >> 8) % (v_active - paddle_h + 1));
        p.p2_y = 10'((lcg_next() >> 8) % (v_active - paddle_h + 1));
        return p;
    endfunction

    // expected colour, stage order background, paddles, overlay
    function automatic logic [11:0] expected_rgb(
        input int          hc,
        input int          vc,
        input paddle_pos_t pos,
        input logic        over
    );
        logic [11:0] c;
        logic        blank;
        blank = (hc >= h_active) || (vc >= v_active);
        if (blank) begin
            c = 12'h000;
        end else if (hc < border_w || hc >= h_active - border_w ||
                     vc < border_w || vc >= v_active - border_w) begin
            c = border_rgb;
        end else begin
            c = bg_rgb;
        end
        // paddles, end exclusive
        if (!blank && hc >= int'(p1_x) && hc < int'(p1_x) + paddle_w &&
            vc >= int'(pos.p1_y) && vc < int'(pos.p1_y) + paddle_h) begin
            c = paddle_rgb;
        end
        if (!blank && hc >= int'(p2_x) && hc < int'(p2_x) + paddle_w &&
            vc >= int'(pos.p2_y) && vc < int'(pos.p2_y) + paddle_h) begin
            c = paddle_rgb;
        end
        // overlay, strictly inside
        for (int i = 0; i < ov_rects; i++) begin
            if (over && hc > int'(ov_x_start[i]) && hc < int'(ov_x_end[i]) &&
                vc > int'(ov_y_start[i]) && vc < int'(ov_y_end[i])) begin
                c = over_rgb;
            end
        end
        return c;
    endfunction

    // interior pixels of all six rectangles, none overlap
    function automatic int overlay_area();
        int sum;
        sum = 0;
        for (int i = 0; i < ov_rects; i++) begin
            sum += (int'(ov_x_end[i]) - int'(ov_x_start[i]) - 1) *
                   (int'(ov_y_end[i]) - int'(ov_y_start[i]) - 1);
        end
        return sum;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
        errors++;
        $display("sim failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic compare_count(input string what, input int exp, input int got);
        if (exp != got) begin
            $display("CHECK FAILED at %0t: %s expected %0d pixels got %0d",
                     $time, what, exp, got);
            errors++;
            $display("sim failed");
            $fatal(1, "stopping on wrong pixel count");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            report_mismatch(name, 64'(exp), 64'(got));
        end
    endtask

    task automatic check_rgb(input string name, input logic [11:0] exp,
                             input logic [11:0] got);
        if (got !== exp) begin
            report_mismatch(name, 64'(exp), 64'(got));
        end
    endtask

    // one output word against its position and the model
    task automatic check_sig(input vga_sig_t got, input int hc, input int vc,
                             input paddle_pos_t pos, input logic over);
        if (got.hcount !== cnt_w'(hc)) begin
            report_mismatch("vga_out.hcount", 64'(hc), 64'(got.hcount));
        end
        if (got.vcount !== cnt_w'(vc)) begin
            report_mismatch("vga_out.vcount", 64'(vc), 64'(got.vcount));
        end
        check_bit("vga_out.hsync", hc >= h_active + h_front &&
                  hc < h_active + h_front + h_sync, got.hsync);
        check_bit("vga_out.vsync", vc >= v_active + v_front &&
                  vc < v_active + v_front + v_sync, got.vsync);
        check_bit("vga_out.hblnk", hc >= h_active, got.hblnk);
        check_bit("vga_out.vblnk", vc >= v_active, got.vblnk);
        check_rgb("vga_out.rgb", expected_rgb(hc, vc, pos, over), got.rgb);
    endtask

    // sample on falling edges until the output shows (h, v)
    task automatic wait_for_pos(input int h, input int v);
        @(negedge clk);
        while (!(vga_out.hcount == cnt_w'(h) && vga_out.vcount == cnt_w'(v))) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_reset_done();
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
    endtask

    // call with the output at the last pixel of the previous frame
    task automatic check_frame(input paddle_pos_t pos, input logic over,
                               output int paddle_cnt, output int over_cnt);
        paddle_cnt = 0;
        over_cnt = 0;
        for (int v = 0; v < v_total; v++) begin
            for (int h = 0; h < h_total; h++) begin
                @(negedge clk);
                check_sig(vga_out, h, v, pos, over);
                if (vga_out.rgb == paddle_rgb) paddle_cnt++;
                if (vga_out.rgb == over_rgb) over_cnt++;
            end
        end
    endtask

    task automatic test_reset_state();
        logic prev_hsync;
        wait_reset_done();
        // one clock out of reset, pipeline still holds reset words
        @(negedge clk);
        if (vga_out !== '0) begin
            report_mismatch("vga_out", 64'(0), 64'(vga_out));
        end
        // first line, pixel 0 looks like a reset word so start at 1
        wait_for_pos(1, 0);
        prev_hsync = 1'b0;
        for (int h = 1; h < h_total; h++) begin
            if (h > 1) @(negedge clk);
            check_sig(vga_out, h, 0, paddles, 1'b0);
            if (vga_out.hsync && !prev_hsync && h != h_active + h_front) begin
                report_mismatch("hsync rise column", 64'(h_active + h_front), 64'(h));
            end
            prev_hsync = vga_out.hsync;
        end
    endtask

    task automatic test_background();
        int pc;
        int oc;
        // paddles sit in vertical blanking, only the blank gate keeps them dark
        wait_for_pos(h_total - 1, v_total - 1);
        check_frame(paddles, 1'b0, pc, oc);
        compare_count("paddle colour in background frame", 0, pc);
        compare_count("overlay colour in background frame", 0, oc);
    endtask

    task automatic test_paddles();
        paddle_pos_t pos;
        int pc;
        int oc;
        for (int f = 0; f < 2; f++) begin
            // new heights while the whole pipeline is in vertical blanking
            wait_for_pos(0, v_active);
            pos = random_paddles();
            paddles = pos;
            wait_for_pos(h_total - 1, v_total - 1);
            check_frame(pos, 1'b0, pc, oc);
            compare_count("paddle colour", paddle_area, pc);
            compare_count("overlay colour before game over", 0, oc);
        end
    endtask

    task automatic test_gameover();
        paddle_pos_t pos;
        int pc;
        int oc;
        wait_for_pos(0, v_active);
        pos = random_paddles();
        paddles = pos;
        // one clock of a nonzero result code
        gameover = gameover_t'((lcg_next() >> 8) % 3 + 1);
        @(negedge clk);
        gameover = go_playing;
        wait_for_pos(h_total - 1, v_total - 1);
        // latch must hold with the input back at zero
        check_frame(pos, 1'b1, pc, oc);
        compare_count("overlay colour", overlay_area(), oc);
        compare_count("paddle colour with overlay", paddle_area, pc);
    endtask

    task automatic test_reset_clears_latch();
        int pc;
        int oc;
        @(negedge clk);
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        wait_reset_done();
        // skip the frame that starts out of reset
        wait_for_pos(h_total - 1, v_total - 1);
        check_frame(paddles, 1'b0, pc, oc);
        compare_count("overlay colour after reset", 0, oc);
        compare_count("paddle colour after reset", paddle_area, pc);
    endtask

    initial begin
        cycles = 0;
        errors = 0;
        lcg_state = 32'hd1853994;
        restart = 1'b0;
        // top line at the first blanked row, whole paddle lands in vblank
        paddles.p1_y = 10'(v_active);
        paddles.p2_y = 10'(v_active);
        gameover = go_playing;

        test_reset_state();
        test_background();
        test_paddles();
        test_gameover();
        test_reset_clears_latch();

        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* src.f */
vga_pkg.sv
game_pkg.sv
vga_timing.sv
draw_background.sv
draw_players.sv
draw_gameover.sv
game_display_top.sv
tb_clock.sv
tb_game_display.sv
